/* Makefile */
TOP := cache_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f -Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	@grep -q "All tests passed!" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir sim.log

/* all.f */
logic/cache_pkg.sv
logic/cache_way.sv
logic/cache_ctrl.sv
logic/cache_top.sv
dv/tb_clk_gen.sv
dv/cache_chk.sv
dv/cache_tb.sv

/* dv/cache_chk.sv */
`timescale 1ns/100ps

module cache_chk (
    input logic clk,
    input logic resetn,
    input logic data_ok,
    input logic rd_req,
    input logic rd_rdy,
    input logic wr_req,
    input logic ret_valid,
    input logic ret_last
);

    logic        refill_pending;
    // count of failed assertions
    int unsigned fail_count = 0;

    // opened by the read handshake, closed by the last beat
    always_ff @(posedge clk) begin
        if (!resetn) begin
            refill_pending <= 1'b0;
        end else if (rd_req && rd_rdy) begin
            refill_pending <= 1'b1;
        end else if (ret_valid && ret_last) begin
            refill_pending <= 1'b0;
        end
    end

    data_ok_single: assert property (@(posedge clk) disable iff (!resetn)
        data_ok |=> !data_ok)
        else begin
            fail_count++;
            $error("data_ok high on two consecutive cycles");
        end

    req_exclusive: assert property (@(posedge clk) disable iff (!resetn)
        !(rd_req && wr_req))
        else begin
            fail_count++;
            $error("rd_req and wr_req high together");
        end

    rd_req_held: assert property (@(posedge clk) disable iff (!resetn)
        (rd_req && !rd_rdy) |=> rd_req)
        else begin
            fail_count++;
            $error("rd_req dropped before rd_rdy");
        end

    beat_in_refill: assert property (@(posedge clk) disable iff (!resetn)
        ret_valid |-> refill_pending)
        else begin
            fail_count++;
            $error("ret_valid with no refill pending");
        end

endmodule

bind cache_top cache_chk u_chk (
    .clk       (clk),
    .resetn    (resetn),
    .data_ok   (data_ok),
    .rd_req    (rd_req),
    .rd_rdy    (rd_rdy),
    .wr_req    (wr_req),
    .ret_valid (ret_valid),
    .ret_last  (ret_last)
);

/* dv/cache_tb.sv */
`timescale 1ns/100ps

module cache_tb;
    import cache_pkg::*;

    localparam int TIMEOUT     = 200;
    localparam int MAX_VECTORS = 64;

    // vector hit classes
    localparam logic [3:0] CLS_HIT   = 4'h1;
    localparam logic [3:0] CLS_MISS  = 4'h2;
    localparam logic [3:0] CLS_CLEAN = 4'h3;
    localparam logic [3:0] CLS_DIRTY = 4'h4;

    logic    clk;
    logic    resetn;
    logic    valid;
    logic    op;
    tag_t    tag;
    index_t  index;
    offset_t offset;
    strobe_t wstrb;
    word_t   wdata;
    logic    addr_ok;
    logic    data_ok;
    word_t   rdata;
    logic    rd_req;
    addr_t   rd_addr;
    logic    rd_rdy;
    logic    ret_valid;
    logic    ret_last;
    word_t   ret_data;
    logic    wr_req;
    addr_t   wr_addr;
    line_t   wr_data;
    logic    wr_rdy;

    // op, address, strobes, write data, class
    logic [75:0] vectors [MAX_VECTORS];
    word_t       mem     [addr_t];
    word_t       shadow  [addr_t];
    logic        touched [addr_t];
    int          elapsed;

    tb_clk_gen u_clk_gen (
        .clk    (clk),
        .resetn (resetn)
    );

    cache_top i_cache_top (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .op        (op),
        .tag       (tag),
        .index     (index),
        .offset    (offset),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    task automatic fail_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_true(input logic cond, input string name, input string what);
        assert (cond) else begin
            $display("%s: %s", name, what);
            fail_run();
        end
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            $display("** Error: %s: expected %h, actual %h", name, expected, actual);
            fail_run();
        end
    endtask

    task automatic check_line(input string name, input line_t expected, input line_t actual);
        assert (actual === expected) else begin
            $display("** Error: %s: expected %h, actual %h", name, expected, actual);
            fail_run();
        end
    endtask

    // inputs change and outputs are read 1 ns after the edge
    task automatic tick();
        @(posedge clk);
        #1;
        elapsed++;
        check_true(i_cache_top.u_chk.fail_count == 0, "protocol",
                   "a bound protocol assertion failed");
    endtask

    task automatic random_delay();
        int unsigned n;
        n = $urandom % 4;
        repeat (n) tick();
    endtask

    // untouched memory reads as the inverted address
    function automatic word_t mem_read(input addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return ~a;
    endfunction

    function automatic word_t shadow_read(input addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return ~a;
    endfunction

    function automatic line_t shadow_line(input addr_t line_addr);
        line_t result;
        for (int w = 0; w < 4; w++) begin
            result[w*32 +: 32] = shadow_read(line_addr + addr_t'(w * 4));
        end
        return result;
    endfunction

    function automatic word_t apply_strobes(input word_t old_word, input word_t new_word,
                                            input strobe_t strb);
        word_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    task automatic serve_write(input string name, input addr_t req_line);
        addr_t victim;
        line_t line;
        victim = wr_addr;
        line   = wr_data;
        check_true(victim[11:4] == req_line[11:4], name, "write-back from another set");
        check_true(victim[3:0] == 4'h0, name, "write-back address not line aligned");
        check_true(victim != req_line, name, "write-back of the requested line");
        check_true(touched.exists(victim), name, "write-back of a line never filled");
        check_line({name, " write-back data"}, shadow_line(victim), line);
        random_delay();
        // address and data must hold under back-pressure
        check_true(wr_req, name, "wr_req dropped before wr_rdy");
        check_word({name, " held wr_addr"}, victim, wr_addr);
        check_line({name, " held wr_data"}, line, wr_data);
        wr_rdy = 1'b1;
        tick();
        wr_rdy = 1'b0;
        for (int w = 0; w < 4; w++) begin
            mem[victim + addr_t'(w * 4)] = line[w*32 +: 32];
        end
    endtask

    task automatic serve_read(input string name, input addr_t req_line);
        check_word({name, " rd_addr"}, req_line, rd_addr);
        random_delay();
        check_true(rd_req, name, "rd_req dropped before rd_rdy");
        rd_rdy = 1'b1;
        tick();
        rd_rdy = 1'b0;
        touched[req_line] = 1'b1;
        for (int b = 0; b < 4; b++) begin
            random_delay();
            ret_valid = 1'b1;
            ret_last  = (b == 3);
            ret_data  = mem_read(req_line + addr_t'(b * 4));
            tick();
            ret_valid = 1'b0;
            ret_last  = 1'b0;
        end
    endtask

    task automatic do_access(input logic [75:0] vec, input int num);
        logic       is_write;
        addr_t      addr;
        strobe_t    strb;
        word_t      data;
        logic [3:0] cls;
        addr_t      line_addr;
        addr_t      word_addr;
        string      name;
        int         start;
        logic       saw_rd;
        logic       saw_wr;

        is_write  = vec[72];
        addr      = vec[71:40];
        strb      = vec[39:36];
        data      = vec[35:4];
        cls       = vec[3:0];
        line_addr = {addr[31:4], 4'h0};
        word_addr = {addr[31:2], 2'b00};
        name      = $sformatf("vector %0d", num);
        saw_rd    = 1'b0;
        saw_wr    = 1'b0;

        valid  = 1'b1;
        op     = is_write;
        tag    = addr[31:12];
        index  = addr[11:4];
        offset = addr[3:0];
        wstrb  = strb;
        wdata  = data;
        start  = elapsed;
        tick();
        valid = 1'b0;
        check_true(addr_ok, name, "addr_ok missing in the lookup cycle");

        // serve the memory side until the request completes
        while (!data_ok) begin
            if (wr_req) begin
                serve_write(name, line_addr);
                saw_wr = 1'b1;
            end else if (rd_req) begin
                serve_read(name, line_addr);
                saw_rd = 1'b1;
            end else begin
                tick();
            end
            check_true(elapsed - start <= TIMEOUT, name, "no data_ok within 200 cycles");
        end

        if (!saw_rd) begin
            check_word({name, " hit latency"}, word_t'(2), word_t'(elapsed - start));
        end
        if (cls == CLS_HIT) begin
            check_true(!saw_rd, name, "expected a hit but the line was refilled");
        end
        if (cls == CLS_MISS || cls == CLS_CLEAN || cls == CLS_DIRTY) begin
            check_true(saw_rd, name, "expected a miss but no refill happened");
        end
        if (cls == CLS_CLEAN) begin
            check_true(!saw_wr, name, "clean victim was written back");
        end
        if (cls == CLS_DIRTY) begin
            check_true(saw_wr, name, "dirty victim was not written back");
        end

        if (is_write) begin
            shadow[word_addr] = apply_strobes(shadow_read(word_addr), data, strb);
        end else begin
            check_word({name, " rdata"}, shadow_read(word_addr), rdata);
        end
    endtask

    initial begin
        int count;
        int start;

        void'($urandom(10654));
        valid     = 1'b0;
        op        = 1'b0;
        tag       = '0;
        index     = '0;
        offset    = '0;
        wstrb     = '0;
        wdata     = '0;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
        elapsed   = 0;
        count     = 0;

        // an op nibble of f ends the list
        for (int i = 0; i < MAX_VECTORS; i++) begin
            vectors[i] = '1;
        end
        $readmemh("dv/cache_vectors.txt", vectors);

        start = elapsed;
        tick();
        while (resetn !== 1'b1) begin
            tick();
            check_true(elapsed - start <= TIMEOUT, "reset", "reset never released");
        end

        // quiet outputs before the first request
        repeat (3) begin
            check_true(!addr_ok && !data_ok, "idle", "addr_ok or data_ok high after reset");
            check_true(!rd_req && !wr_req, "idle", "memory request high after reset");
            tick();
        end

        for (int i = 0; i < MAX_VECTORS; i++) begin
            if (vectors[i][75:72] == 4'hF) begin
                break;
            end
            do_access(vectors[i], i);
            count++;
        end
        check_true(count > 0, "vector file", "no vectors were read");

        $display("%0d accesses checked", count);
        $display("All tests passed!");
        $finish;
    end

endmodule

/* dv/cache_vectors.txt */
// op _ address _ strobes _ write data _ class (one hex word per access)
// class: 0 either, 1 hit, 2 miss, 3 miss without write-back, 4 miss with write-back
0_00001104_0_00000000_3
0_00001108_0_00000000_1
0_00002100_0_00000000_3
0_0000110C_0_00000000_1
0_0000210C_0_00000000_1
1_00001104_3_A5A51234_1
0_00001104_0_00000000_1
1_00003208_C_BEEF0000_3
0_00003208_0_00000000_1
1_00002100_F_12345678_1
0_00004100_0_00000000_4
0_00001104_0_00000000_0
0_00002100_0_00000000_0
0_00005300_0_00000000_3
0_00006304_0_00000000_3
0_00007308_0_00000000_3
0_00005300_0_00000000_0
1_0000530C_1_000000AB_0
0_0000530C_0_00000000_1

/* dv/tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // reset low across the first two rising edges
    initial begin
        resetn = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        resetn = 1'b1;
    end

endmodule

/* logic/cache_ctrl.sv */
`timescale 1ns/100ps

module cache_ctrl (
    input  logic                 clk,
    input  logic                 resetn,
    // cpu side
    input  logic                 valid,
    input  logic                 op,
    input  cache_pkg::tag_t      tag,
    input  cache_pkg::index_t    index,
    input  cache_pkg::offset_t   offset,
    input  cache_pkg::strobe_t   wstrb,
    input  cache_pkg::word_t     wdata,
    output logic                 addr_ok,
    output logic                 data_ok,
    output cache_pkg::word_t     rdata,
    // memory read side
    output logic                 rd_req,
    output cache_pkg::addr_t     rd_addr,
    input  logic                 rd_rdy,
    input  logic                 ret_valid,
    input  logic                 ret_last,
    input  cache_pkg::word_t     ret_data,
    // memory write side
    output logic                 wr_req,
    output cache_pkg::addr_t     wr_addr,
    output cache_pkg::line_t     wr_data,
    input  logic                 wr_rdy,
    // way storage
    output cache_pkg::index_t    ram_index,
    input  cache_pkg::tag_t      way0_tag,
    input  cache_pkg::tag_t      way1_tag,
    input  logic                 way0_valid,
    input  logic                 way1_valid,
    input  logic                 way0_dirty,
    input  logic                 way1_dirty,
    input  cache_pkg::line_t     way0_line,
    input  cache_pkg::line_t     way1_line,
    output logic [1:0]           meta_we,
    output cache_pkg::tag_t      meta_tag,
    output logic                 meta_dirty,
    output logic [1:0]           dirty_set,
    output cache_pkg::strobe_t   data_we,
    output logic                 data_way,
    output cache_pkg::word_sel_t data_word,
    output cache_pkg::word_t     data_wdata
);
    import cache_pkg::*;

    function automatic word_t get_word(input line_t line, input word_sel_t sel);
        return line[sel*$bits(word_t) +: $bits(word_t)];
    endfunction

    function automatic word_t merge_word(input word_t old_word, input word_t new_word,
                                         input strobe_t strb);
        word_t result;
        result = old_word;
        for (int b = 0; b < $bits(strobe_t); b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    cache_state_t state;
    cache_state_t state_next;

    // request buffer
    logic      op_r;
    tag_t      tag_r;
    index_t    index_r;
    word_sel_t word_r;
    strobe_t   wstrb_r;
    word_t     wdata_r;

    logic        way0_hit;
    logic        way1_hit;
    logic        cache_hit;
    word_t       hit_word;
    logic        victim_pick;
    logic        victim_dirty;
    logic        victim_way;
    logic [22:0] lfsr;
    word_sel_t   beat_cnt;
    word_t       refill_word;
    logic        refill_done;

    assign way0_hit  = way0_valid && (way0_tag == tag_r);
    assign way1_hit  = way1_valid && (way1_tag == tag_r);
    assign cache_hit = way0_hit || way1_hit;
    assign hit_word  = get_word(way1_hit ? way1_line : way0_line, word_r);

    // invalid ways fill first, random pick once both are valid
    assign victim_pick  = !way0_valid ? 1'b0 :
                          !way1_valid ? 1'b1 : lfsr[0];
    assign victim_dirty = victim_pick ? (way1_valid && way1_dirty)
                                      : (way0_valid && way0_dirty);

    // missed store merges into its own beat
    assign refill_word = (op_r && beat_cnt == word_r) ? merge_word(ret_data, wdata_r, wstrb_r)
                                                      : ret_data;
    assign refill_done = (state == REFILL) && ret_valid && ret_last;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (valid) begin
                    state_next = LOOKUP;
                end
            end
            LOOKUP: begin
                if (cache_hit) begin
                    state_next = IDLE;
                end else if (victim_dirty) begin
                    state_next = MISS;
                end else begin
                    state_next = REPLACE;
                end
            end
            MISS: begin
                if (wr_rdy) begin
                    state_next = REPLACE;
                end
            end
            REPLACE: begin
                if (rd_rdy) begin
                    state_next = REFILL;
                end
            end
            REFILL: begin
                if (ret_valid && ret_last) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && valid) begin
            op_r    <= op;
            tag_r   <= tag;
            index_r <= index;
            word_r  <= offset[3:2];
            wstrb_r <= wstrb;
            wdata_r <= wdata;
        end
    end

    // control registers
    always_ff @(posedge clk) begin
        if (!resetn) begin
            lfsr       <= LFSR_SEED;
            victim_way <= 1'b0;
            beat_cnt   <= '0;
            data_ok    <= 1'b0;
        end else begin
            lfsr    <= {lfsr[21:0], lfsr[22] ^ lfsr[17]};
            data_ok <= ((state == LOOKUP) && cache_hit) || refill_done;
            if (state == LOOKUP) begin
                victim_way <= victim_pick;
            end
            if (state != REFILL) begin
                beat_cnt <= '0;
            end else if (ret_valid) begin
                beat_cnt <= beat_cnt + 2'd1;
            end
        end
    end

    // victim line held for write-back
    always_ff @(posedge clk) begin
        if (state == LOOKUP && !cache_hit) begin
            wr_addr <= {(victim_pick ? way1_tag : way0_tag), index_r, offset_t'(0)};
            wr_data <= victim_pick ? way1_line : way0_line;
        end
    end

    always_ff @(posedge clk) begin
        if (state == LOOKUP && cache_hit) begin
            rdata <= hit_word;
        end else if (state == REFILL && ret_valid && beat_cnt == word_r) begin
            rdata <= refill_word;
        end
    end

    assign addr_ok   = (state == LOOKUP);
    assign wr_req    = (state == MISS);
    assign rd_req    = (state == REPLACE);
    assign rd_addr   = {tag_r, index_r, offset_t'(0)};
    assign ram_index = (state == IDLE) ? index : index_r;

    // metadata writes
    assign meta_we    = {2{refill_done}} & {victim_way, ~victim_way};
    assign meta_tag   = tag_r;
    assign meta_dirty = op_r;
    assign dirty_set  = {2{(state == LOOKUP) && op_r}} & {way1_hit, way0_hit};

    // data writes from a hit store or a refill beat
    always_comb begin
        data_we    = '0;
        data_way   = victim_way;
        data_word  = beat_cnt;
        data_wdata = refill_word;
        if (state == LOOKUP && cache_hit && op_r) begin
            data_we    = wstrb_r;
            data_way   = way1_hit;
            data_word  = word_r;
            data_wdata = wdata_r;
        end else if (state == REFILL && ret_valid) begin
            data_we = '1;
        end
    end

endmodule

/* logic/cache_pkg.sv */
package cache_pkg;

    // cache geometry
    localparam int NUM_SETS       = 256;
    localparam int WORDS_PER_LINE = 4;

    // replacement LFSR reset value
    localparam logic [22:0] LFSR_SEED = 23'h4A528A;

    // address fields
    typedef logic [31:0] addr_t;
    // addr[31:12]
    typedef logic [19:0] tag_t;
    // addr[11:4]
    typedef logic [7:0]  index_t;
    // addr[3:0]
    typedef logic [3:0]  offset_t;

    // word in a line, doubles as refill beat number
    typedef logic [1:0]  word_sel_t;

    // data
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strobe_t;
    typedef logic [WORDS_PER_LINE*32-1:0] line_t;

    // controller states
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        LOOKUP  = 3'd1,
        MISS    = 3'd2,
        REPLACE = 3'd3,
        REFILL  = 3'd4
    } cache_state_t;

endpackage

/* logic/cache_top.sv */
`timescale 1ns/100ps

module cache_top (
    input  logic               clk,
    input  logic               resetn,
    // cpu side
    input  logic               valid,
    input  logic               op,
    input  cache_pkg::tag_t    tag,
    input  cache_pkg::index_t  index,
    input  cache_pkg::offset_t offset,
    input  cache_pkg::strobe_t wstrb,
    input  cache_pkg::word_t   wdata,
    output logic               addr_ok,
    output logic               data_ok,
    output cache_pkg::word_t   rdata,
    // memory read side
    output logic               rd_req,
    output cache_pkg::addr_t   rd_addr,
    input  logic               rd_rdy,
    input  logic               ret_valid,
    input  logic               ret_last,
    input  cache_pkg::word_t   ret_data,
    // memory write side
    output logic               wr_req,
    output cache_pkg::addr_t   wr_addr,
    output cache_pkg::line_t   wr_data,
    input  logic               wr_rdy
);
    import cache_pkg::*;

    index_t    ram_index;
    tag_t      way0_tag;
    tag_t      way1_tag;
    logic      way0_valid;
    logic      way1_valid;
    logic      way0_dirty;
    logic      way1_dirty;
    line_t     way0_line;
    line_t     way1_line;
    logic [1:0] meta_we;
    tag_t      meta_tag;
    logic      meta_dirty;
    logic [1:0] dirty_set;
    strobe_t   data_we;
    logic      data_way;
    word_sel_t data_word;
    word_t     data_wdata;
    strobe_t   way0_data_we;
    strobe_t   way1_data_we;

    // steer the data write to the selected way only
    assign way0_data_we = data_way ? '0 : data_we;
    assign way1_data_we = data_way ? data_we : '0;

    cache_ctrl u_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .valid      (valid),
        .op         (op),
        .tag        (tag),
        .index      (index),
        .offset     (offset),
        .wstrb      (wstrb),
        .wdata      (wdata),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_rdy     (rd_rdy),
        .ret_valid  (ret_valid),
        .ret_last   (ret_last),
        .ret_data   (ret_data),
        .wr_req     (wr_req),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_rdy     (wr_rdy),
        .ram_index  (ram_index),
        .way0_tag   (way0_tag),
        .way1_tag   (way1_tag),
        .way0_valid (way0_valid),
        .way1_valid (way1_valid),
        .way0_dirty (way0_dirty),
        .way1_dirty (way1_dirty),
        .way0_line  (way0_line),
        .way1_line  (way1_line),
        .meta_we    (meta_we),
        .meta_tag   (meta_tag),
        .meta_dirty (meta_dirty),
        .dirty_set  (dirty_set),
        .data_we    (data_we),
        .data_way   (data_way),
        .data_word  (data_word),
        .data_wdata (data_wdata)
    );

    cache_way u_way0 (
        .clk        (clk),
        .resetn     (resetn),
        .ram_index  (ram_index),
        .meta_we    (meta_we[0]),
        .meta_dirty (meta_dirty),
        .dirty_set  (dirty_set[0]),
        .meta_tag   (meta_tag),
        .data_we    (way0_data_we),
        .data_word  (data_word),
        .data_wdata (data_wdata),
        .tag_q      (way0_tag),
        .valid_q    (way0_valid),
        .dirty_q    (way0_dirty),
        .line_q     (way0_line)
    );

    cache_way u_way1 (
        .clk        (clk),
        .resetn     (resetn),
        .ram_index  (ram_index),
        .meta_we    (meta_we[1]),
        .meta_dirty (meta_dirty),
        .dirty_set  (dirty_set[1]),
        .meta_tag   (meta_tag),
        .data_we    (way1_data_we),
        .data_word  (data_word),
        .data_wdata (data_wdata),
        .tag_q      (way1_tag),
        .valid_q    (way1_valid),
        .dirty_q    (way1_dirty),
        .line_q     (way1_line)
    );

endmodule

/* logic/cache_way.sv */
`timescale 1ns/100ps

module cache_way (
    input  logic                 clk,
    input  logic                 resetn,
    input  cache_pkg::index_t    ram_index,
    input  logic                 meta_we,
    input  logic                 meta_dirty,
    input  logic                 dirty_set,
    input  cache_pkg::tag_t      meta_tag,
    input  cache_pkg::strobe_t   data_we,
    input  cache_pkg::word_sel_t data_word,
    input  cache_pkg::word_t     data_wdata,
    output cache_pkg::tag_t      tag_q,
    output logic                 valid_q,
    output logic                 dirty_q,
    output cache_pkg::line_t     line_q
);
    import cache_pkg::*;

    logic [NUM_SETS-1:0] valid_bits;
    logic [NUM_SETS-1:0] dirty_bits;
    tag_t  tag_mem  [NUM_SETS];
    word_t data_mem [NUM_SETS][WORDS_PER_LINE];

    // state bits, cleared on reset
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            valid_q    <= 1'b0;
            dirty_q    <= 1'b0;
        end else begin
            valid_q <= valid_bits[ram_index];
            dirty_q <= dirty_bits[ram_index];
            // refill completion rewrites both bits
            if (meta_we) begin
                valid_bits[ram_index] <= 1'b1;
                dirty_bits[ram_index] <= meta_dirty;
            end else if (dirty_set) begin
                dirty_bits[ram_index] <= 1'b1;
            end
        end
    end

    // tag array
    always_ff @(posedge clk) begin
        tag_q <= tag_mem[ram_index];
        if (meta_we) begin
            tag_mem[ram_index] <= meta_tag;
        end
    end

    // line array, one byte lane per strobe bit
    always_ff @(posedge clk) begin
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            line_q[w*$bits(word_t) +: $bits(word_t)] <= data_mem[ram_index][w];
        end
        for (int b = 0; b < $bits(strobe_t); b++) begin
            if (data_we[b]) begin
                data_mem[ram_index][data_word][b*8 +: 8] <= data_wdata[b*8 +: 8];
            end
        end
    end

endmodule
